/* Makefile */
# Verilator simulation of the RNG subsystem testbench

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module rng_tb -Mdir obj_dir
	./obj_dir/Vrng_tb | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* build.f */
+incdir+test
design/rng_pkg.sv
design/entropy_collector.sv
design/seed_conditioner.sv
design/drbg_core.sv
design/output_buffer.sv
design/rng_top.sv
test/rng_tb.sv

/* design/drbg_core.sv */
// DRBG core
// xorshift64 generator; offers one word per handshake and asks for
// a fresh seed after every RESEED_INTERVAL words
`default_nettype none

module drbg_core import rng_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rs_req,
    output logic  rs_ack,
    input  seed_t rs_seed,
    output logic  rn_req,
    input  logic  rn_ack,
    output seed_t rn_word
);

    typedef enum logic [2:0] {
        NEED_SEED,
        SEED_REL,   // Seed taken, waiting for req to drop
        STEP,
        OFFER,
        OFFER_REL   // Word taken, waiting for ack to drop
    } drbg_state_t;

    drbg_state_t             state;
    seed_t                   xs_state;
    seed_t                   reseeded;
    logic [RESEED_CNT_W-1:0] word_cnt;

    function automatic seed_t xs_step(seed_t x);
        seed_t y;
        y = x ^ (x << XS_SHIFT_A);
        y = y ^ (y >> XS_SHIFT_B);
        y = y ^ (y << XS_SHIFT_C);
        return y;
    endfunction

    assign reseeded = xs_state ^ rs_seed;
    assign rn_req   = (state == OFFER);
    assign rn_word  = xs_state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= NEED_SEED;
            xs_state <= '0;
            rs_ack   <= 1'b0;
            word_cnt <= '0;
        end else begin
            unique case (state)
                NEED_SEED: begin
                    if (rs_req) begin
                        xs_state <= (reseeded == '0) ? '1 : reseeded;  // Never a zero state
                        rs_ack   <= 1'b1;
                        state    <= SEED_REL;
                    end
                end
                SEED_REL: begin
                    if (!rs_req) begin
                        rs_ack <= 1'b0;
                        state  <= STEP;
                    end
                end
                STEP: begin
                    xs_state <= xs_step(xs_state);  // Advance before offering
                    state    <= OFFER;
                end
                OFFER: begin
                    if (rn_ack) begin
                        word_cnt <= (word_cnt == RESEED_CNT_W'(RESEED_INTERVAL - 1)) ?
                                    '0 : word_cnt + 1'b1;
                        state    <= OFFER_REL;
                    end
                end
                OFFER_REL: begin
                    if (!rn_ack) begin
                        state <= (word_cnt == '0) ? NEED_SEED : STEP;
                    end
                end
                default: state <= NEED_SEED;
            endcase
        end
    end

    a_word_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rn_req && !rn_ack |=> $stable(rn_word));

endmodule

`default_nettype wire

/* design/entropy_collector.sv */
// Entropy collector
// Packs accepted raw noise bits into 128-bit blocks, first bit in bit 0,
// and runs the repetition count health test on the incoming stream
`default_nettype none

module entropy_collector import rng_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       raw_bit,
    input  logic       raw_valid,
    output logic       raw_ready,
    output logic       blk_req,
    input  logic       blk_ack,
    output raw_block_t blk_data,
    output logic       health_fail
);

    typedef enum logic [1:0] {
        COLLECT,
        HOLD,     // Block offered, waiting for ack
        RELEASE   // Waiting for ack to drop
    } col_state_t;

    col_state_t           state;
    logic [BLK_CNT_W-1:0] bit_cnt;
    logic [RUN_CNT_W-1:0] run_len;   // Zero means no previous bit
    logic [RUN_CNT_W-1:0] run_next;
    logic                 last_bit;
    logic                 accept;

    assign raw_ready = (state == COLLECT);
    assign blk_req   = (state == HOLD);
    assign accept    = raw_valid && raw_ready;

    always_comb begin
        if (run_len != '0 && raw_bit == last_bit) begin
            run_next = run_len + 1'b1;
        end else begin
            run_next = RUN_CNT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= COLLECT;
            bit_cnt     <= '0;
            run_len     <= '0;
            last_bit    <= 1'b0;
            health_fail <= 1'b0;
        end else begin
            unique case (state)
                COLLECT: begin
                    if (accept) begin
                        last_bit <= raw_bit;
                        if (run_next == RUN_CNT_W'(REP_LIMIT)) begin
                            health_fail <= 1'b1;  // Sticky until reset
                            bit_cnt     <= '0;    // Drop partial block
                            run_len     <= '0;    // Next bit starts a run of 1
                        end else begin
                            run_len <= run_next;
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == BLK_CNT_W'(RAW_BLOCK_BITS - 1)) begin
                                state <= HOLD;
                            end
                        end
                    end
                end
                HOLD:    if (blk_ack)  state <= RELEASE;
                RELEASE: if (!blk_ack) state <= COLLECT;
                default: state <= COLLECT;
            endcase
        end
    end

    // Shift in from the top so the first bit lands in bit 0
    always_ff @(posedge clk) begin
        if (accept && run_next != RUN_CNT_W'(REP_LIMIT)) begin
            blk_data <= {raw_bit, blk_data[RAW_BLOCK_BITS-1:1]};
        end
    end

    a_blk_stable: assert property (@(posedge clk) disable iff (!rst_n)
        blk_req && !blk_ack |=> $stable(blk_data));

endmodule

`default_nettype wire

/* design/output_buffer.sv */
// Output buffer
// Holds a small seed queue and one DRBG word, and returns RDSEED and RDRAND
// results to the host one byte per cycle, least significant byte first
`default_nettype none

module output_buffer import rng_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sq_req,
    output logic       sq_ack,
    input  seed_t      sq_seed,
    input  logic       rn_req,
    output logic       rn_ack,
    input  seed_t      rn_word,
    input  logic       cpu_req,
    input  rand_req_t  cpu_type,
    output logic [7:0] cpu_byte,
    output logic       cpu_byte_valid,
    output logic       cpu_ack
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_DATA,
        SEND,
        ACK
    } buf_state_t;

    buf_state_t          state;
    rand_req_t           req_type;
    seed_t               queue [SEED_QUEUE_DEPTH];
    logic [SQ_PTR_W-1:0] wr_ptr;
    logic [SQ_PTR_W-1:0] rd_ptr;
    logic [SQ_CNT_W-1:0] count;
    logic                full;
    logic                push;
    logic                pop;
    seed_t               rand_word;
    logic                rand_held;
    logic                take_rand;
    logic                is_seed;
    seed_t               out_word;   // Shifts down one byte per sent byte
    logic [2:0]          bytes_left;

    // Index of the last byte for a request kind
    function automatic logic [2:0] last_byte(rand_req_t t);
        unique case (t)
            RDRAND_16, RDSEED_16: return 3'd1;
            RDRAND_32, RDSEED_32: return 3'd3;
            default:              return 3'd7;
        endcase
    endfunction

    assign full      = (count == SQ_CNT_W'(SEED_QUEUE_DEPTH));
    assign push      = sq_req && !sq_ack && !full;
    assign is_seed   = (req_type inside {RDSEED_16, RDSEED_32, RDSEED_64});
    assign pop       = (state == WAIT_DATA) && is_seed && (count != '0);
    assign take_rand = (state == WAIT_DATA) && !is_seed && rand_held;

    assign cpu_byte       = out_word[7:0];
    assign cpu_byte_valid = (state == SEND);
    assign cpu_ack        = (state == ACK);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sq_ack    <= 1'b0;
            rn_ack    <= 1'b0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            rand_held <= 1'b0;
        end else begin
            if (push) begin
                sq_ack <= 1'b1;
                wr_ptr <= wr_ptr + 1'b1;
            end else if (sq_ack && !sq_req) begin
                sq_ack <= 1'b0;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + SQ_CNT_W'(push) - SQ_CNT_W'(pop);

            // Rand register only accepts a word when empty
            if (rn_req && !rn_ack && !rand_held) begin
                rn_ack    <= 1'b1;
                rand_held <= 1'b1;
            end else begin
                if (rn_ack && !rn_req) rn_ack <= 1'b0;
                if (take_rand)         rand_held <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= sq_seed;
        end
        if (rn_req && !rn_ack && !rand_held) begin
            rand_word <= rn_word;
        end
    end

    // Host request FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            req_type   <= RDRAND_16;
            bytes_left <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (cpu_req) begin
                        req_type <= cpu_type;
                        state    <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (pop || take_rand) begin
                        bytes_left <= last_byte(req_type);
                        state      <= SEND;
                    end
                end
                SEND: begin
                    bytes_left <= bytes_left - 1'b1;
                    if (bytes_left == '0) state <= ACK;  // Upper bytes dropped
                end
                ACK:     if (!cpu_req) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_word <= queue[rd_ptr];
        end else if (take_rand) begin
            out_word <= rand_word;
        end else if (state == SEND) begin
            out_word <= out_word >> 8;
        end
    end

    a_no_full_push: assert property (@(posedge clk) disable iff (!rst_n)
        sq_req && !sq_ack && full |=> !sq_ack);
    a_valid_not_ack: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ack |-> !cpu_byte_valid);

endmodule

`default_nettype wire

/* design/rng_pkg.sv */
// RNG subsystem shared definitions
// Host request kinds, payload types and sizing constants used across the design
`default_nettype none

package rng_pkg;

    localparam int RAW_BLOCK_BITS   = 128;  // Raw bits per collected block
    localparam int SEED_BITS        = 64;   // Seed and DRBG word width
    localparam int REP_LIMIT        = 32;   // Failing run of identical bits
    localparam int MIX_ROUNDS       = 4;    // One round per clock
    localparam int RESEED_INTERVAL  = 4;
    localparam int SEED_QUEUE_DEPTH = 4;

    // xorshift64 shift amounts
    localparam int XS_SHIFT_A = 13;
    localparam int XS_SHIFT_B = 7;
    localparam int XS_SHIFT_C = 17;

    localparam int MIX_ROTATE = 23;  // Conditioner rotate left amount

    // Counter and pointer widths
    localparam int BLK_CNT_W    = $clog2(RAW_BLOCK_BITS);
    localparam int RUN_CNT_W    = $clog2(REP_LIMIT) + 1;
    localparam int ROUND_CNT_W  = $clog2(MIX_ROUNDS);
    localparam int RESEED_CNT_W = $clog2(RESEED_INTERVAL);
    localparam int SQ_PTR_W     = $clog2(SEED_QUEUE_DEPTH);
    localparam int SQ_CNT_W     = $clog2(SEED_QUEUE_DEPTH + 1);

    typedef logic [RAW_BLOCK_BITS-1:0] raw_block_t;
    typedef logic [SEED_BITS-1:0]      seed_t;

    // Host request kinds
    typedef enum logic [2:0] {
        RDRAND_16 = 3'd0,
        RDRAND_32 = 3'd1,
        RDRAND_64 = 3'd2,
        RDSEED_16 = 3'd3,
        RDSEED_32 = 3'd4,
        RDSEED_64 = 3'd5
    } rand_req_t;

endpackage

`default_nettype wire

/* design/rng_top.sv */
// RNG subsystem top level
// Entropy collector, seed conditioner, DRBG and output buffer chained
// by four-phase req/ack links
`default_nettype none

module rng_top import rng_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       raw_bit,
    input  logic       raw_valid,
    output logic       raw_ready,
    input  logic       cpu_req,
    input  rand_req_t  cpu_type,
    output logic [7:0] cpu_byte,
    output logic       cpu_byte_valid,
    output logic       cpu_ack,
    output logic       health_fail
);

    logic       blk_req;
    logic       blk_ack;
    raw_block_t blk_data;
    logic       rs_req;
    logic       rs_ack;
    seed_t      rs_seed;
    logic       sq_req;
    logic       sq_ack;
    seed_t      sq_seed;
    logic       rn_req;
    logic       rn_ack;
    seed_t      rn_word;

    entropy_collector collector_i (
        .clk, .rst_n,
        .raw_bit, .raw_valid, .raw_ready,
        .blk_req, .blk_ack, .blk_data,
        .health_fail
    );

    seed_conditioner conditioner_i (
        .clk, .rst_n,
        .blk_req, .blk_ack, .blk_data,
        .rs_req, .rs_ack, .rs_seed,
        .sq_req, .sq_ack, .sq_seed
    );

    drbg_core drbg_i (
        .clk, .rst_n,
        .rs_req, .rs_ack, .rs_seed,
        .rn_req, .rn_ack, .rn_word
    );

    output_buffer buffer_i (
        .clk, .rst_n,
        .sq_req, .sq_ack, .sq_seed,
        .rn_req, .rn_ack, .rn_word,
        .cpu_req, .cpu_type, .cpu_byte, .cpu_byte_valid, .cpu_ack
    );

endmodule

`default_nettype wire

/* design/seed_conditioner.sv */
// Seed conditioner
// Folds each raw block into a 64-bit seed over MIX_ROUNDS cycles, then routes
// every RESEED_INTERVAL-th seed to the DRBG and the rest to the seed queue
`default_nettype none

module seed_conditioner import rng_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       blk_req,
    output logic       blk_ack,
    input  raw_block_t blk_data,
    output logic       rs_req,
    input  logic       rs_ack,
    output seed_t      rs_seed,
    output logic       sq_req,
    input  logic       sq_ack,
    output seed_t      sq_seed
);

    typedef enum logic [1:0] {
        IDLE,
        MIX,
        ROUTE,   // Route req high
        DONE     // Waiting for route ack to drop
    } cond_state_t;

    cond_state_t             state;
    seed_t                   lo;
    seed_t                   hi;
    seed_t                   lo_next;
    seed_t                   seed;
    logic [ROUND_CNT_W-1:0]  round_cnt;
    logic [RESEED_CNT_W-1:0] seed_cnt;
    logic                    route_drbg;
    logic                    route_ack;
    logic                    take_blk;

    // Low half takes the high half rotated left, high half adds the new low
    assign lo_next = lo ^ ((hi << MIX_ROTATE) | (hi >> (SEED_BITS - MIX_ROTATE)));
    assign seed    = lo ^ hi;
    assign rs_seed = seed;
    assign sq_seed = seed;

    assign rs_req    = (state == ROUTE) && route_drbg;
    assign sq_req    = (state == ROUTE) && !route_drbg;
    assign route_ack = route_drbg ? rs_ack : sq_ack;
    assign take_blk  = (state == IDLE) && blk_req && !blk_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            blk_ack    <= 1'b0;
            round_cnt  <= '0;
            seed_cnt   <= '0;
            route_drbg <= 1'b0;
        end else begin
            if (take_blk) begin
                blk_ack <= 1'b1;
            end else if (blk_ack && !blk_req) begin
                blk_ack <= 1'b0;
            end

            unique case (state)
                IDLE: begin
                    if (take_blk) begin
                        round_cnt <= '0;
                        state     <= MIX;
                    end
                end
                MIX: begin
                    round_cnt <= round_cnt + 1'b1;
                    if (round_cnt == ROUND_CNT_W'(MIX_ROUNDS - 1)) begin
                        route_drbg <= (seed_cnt == '0);  // Seed 0, 4, 8 ... reseeds
                        state      <= ROUTE;
                    end
                end
                ROUTE: if (route_ack) state <= DONE;  // Halts here when the queue is full
                DONE: begin
                    if (!route_ack) begin
                        seed_cnt <= (seed_cnt == RESEED_CNT_W'(RESEED_INTERVAL - 1)) ?
                                    '0 : seed_cnt + 1'b1;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Mixing halves are payload
    always_ff @(posedge clk) begin
        if (take_blk) begin
            lo <= blk_data[SEED_BITS-1:0];
            hi <= blk_data[RAW_BLOCK_BITS-1:SEED_BITS];
        end else if (state == MIX) begin
            lo <= lo_next;
            hi <= hi + lo_next;
        end
    end

    a_one_route: assert property (@(posedge clk) disable iff (!rst_n)
        !(rs_req && sq_req));

endmodule

`default_nettype wire

/* test/rng_model.svh */
// RNG reference model
// Conditioner mixing, xorshift64 step, DRBG reseed and seed routing rules
`ifndef RNG_MODEL_SVH
`define RNG_MODEL_SVH

// Rounds of rotate-XOR into the low half, then add into the high half
function automatic seed_t mix_block(raw_block_t blk);
    seed_t lo;
    seed_t hi;
    int    r;
    lo = blk[SEED_BITS-1:0];
    hi = blk[RAW_BLOCK_BITS-1:SEED_BITS];
    for (r = 0; r < MIX_ROUNDS; r++) begin
        lo = lo ^ {hi[SEED_BITS-MIX_ROTATE-1:0], hi[SEED_BITS-1:SEED_BITS-MIX_ROTATE]};
        hi = hi + lo;
    end
    return lo ^ hi;
endfunction

function automatic seed_t xorshift_step(seed_t x);
    x = x ^ (x << XS_SHIFT_A);
    x = x ^ (x >> XS_SHIFT_B);
    x = x ^ (x << XS_SHIFT_C);
    return x;
endfunction

function automatic seed_t reseed_state(seed_t st, seed_t s);
    seed_t r;
    r = st ^ s;
    if (r == '0) begin
        r = '1;  // Zero state would lock the generator
    end
    return r;
endfunction

function automatic logic goes_to_drbg(int k);
    return (k % RESEED_INTERVAL) == 0;
endfunction

`endif

/* test/rng_tb.sv */
// RNG subsystem testbench
// Random raw bits with forced repeat runs feed the DUT while a host driver
// issues RDRAND and RDSEED requests checked against a reference model
`default_nettype none

module rng_tb import rng_pkg::*; ();

    logic       clk;
    logic       rst_n;
    logic       raw_bit;
    logic       raw_valid;
    logic       raw_ready;
    logic       cpu_req;
    rand_req_t  cpu_type;
    logic [7:0] cpu_byte;
    logic       cpu_byte_valid;
    logic       cpu_ack;
    logic       health_fail;

    integer seed;
    integer host_seed;
    integer raw_rnd;
    int     errors;
    int     checks;

    // Reference model state
    raw_block_t m_blk;
    int         m_cnt;
    int         m_run;
    logic       m_last;
    logic       exp_health;
    seed_t      drbg_st;
    int         seed_count;
    seed_t      exp_seed[$];
    int         exp_seed_idx[$];  // Global seed number of each queued seed
    seed_t      exp_rand[$];
    int         seeds_read;
    int         rand_read;

    logic raw_on;
    logic host_busy;
    int   stretch_left;
    logic stretch_val;
    int   cyc;
    int   ready_low_run;  // Consecutive cycles with raw_ready low

    `include "rng_model.svh"

    rng_top dut_i (
        .clk, .rst_n,
        .raw_bit, .raw_valid, .raw_ready,
        .cpu_req, .cpu_type, .cpu_byte, .cpu_byte_valid, .cpu_ack,
        .health_fail
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at time %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        errors++;
        $display("Timeout: %s", what);
        finish_run();
    endtask

    task automatic model_block();
        seed_t s;
        s = mix_block(m_blk);
        if (goes_to_drbg(seed_count)) begin
            drbg_st = reseed_state(drbg_st, s);
            repeat (RESEED_INTERVAL) begin
                drbg_st = xorshift_step(drbg_st);
                exp_rand.push_back(drbg_st);
            end
        end else begin
            exp_seed.push_back(s);
            exp_seed_idx.push_back(seed_count);
        end
        seed_count++;
    endtask

    // Run length test before packing from bit 0 upward
    task automatic model_bit(input logic b);
        if (m_run != 0 && b == m_last) begin
            m_run++;
        end else begin
            m_run = 1;
        end
        m_last = b;
        if (m_run == REP_LIMIT) begin
            exp_health = 1'b1;
            m_cnt      = 0;  // Partial block is lost
            m_run      = 0;
        end else begin
            m_blk[m_cnt] = b;
            m_cnt++;
            if (m_cnt == RAW_BLOCK_BITS) begin
                m_cnt = 0;
                model_block();
            end
        end
    endtask

    // A seed leaves the conditioner only after the DRBG took every earlier reseed
    // and that needs all but the last word of the previous reseed read by the host
    function automatic logic can_read_seed();
        int j;
        if (exp_seed.size() == 0) return 1'b0;
        j = exp_seed_idx[0] / RESEED_INTERVAL;
        return (j == 0) || (rand_read >= RESEED_INTERVAL * j - 1);
    endfunction

    // The reseed behind the next word must get past a queue with free room
    function automatic logic can_read_rand();
        int j;
        if (exp_rand.size() == 0) return 1'b0;
        j = rand_read / RESEED_INTERVAL;
        return seeds_read >= (RESEED_INTERVAL - 1) * j - SEED_QUEUE_DEPTH;
    endfunction

    // Raw bit source, model feed and per-cycle monitors
    always @(negedge clk) begin
        if (raw_on) begin
            check_value("health_fail", health_fail, exp_health);
            check_value("cpu_byte_valid (idle)", cpu_byte_valid && !host_busy, 0);
            raw_rnd = $random(seed);
            cyc++;
            if (stretch_left == 0 && (cyc == 300 || ($unsigned(raw_rnd) >> 9) % 400 == 0)) begin
                stretch_left = REP_LIMIT + 4;
                stretch_val  = raw_rnd[5];
            end
            if (stretch_left > 0) begin
                raw_valid = 1'b1;
                raw_bit   = stretch_val;
            end else begin
                raw_valid = (raw_rnd[3:1] != 3'd0);
                raw_bit   = raw_rnd[0];
            end
            if (raw_valid && raw_ready) begin  // Taken at the next rising edge
                model_bit(raw_bit);
                if (stretch_left > 0) stretch_left--;
            end
            ready_low_run = raw_ready ? 0 : ready_low_run + 1;
        end
    end

    task automatic host_request(input logic is_seed, input int size);
        seed_t exp_word;
        int    nbytes;
        int    wait_cyc;
        int    i;
        nbytes = 2 << size;
        if (is_seed) begin
            exp_word = exp_seed.pop_front();
            void'(exp_seed_idx.pop_front());
            seeds_read++;
        end else begin
            exp_word = exp_rand.pop_front();
            rand_read++;
        end
        host_busy = 1'b1;
        cpu_req   = 1'b1;
        cpu_type  = rand_req_t'(is_seed ? 3 + size : size);
        wait_cyc  = 0;
        @(negedge clk);
        while (!cpu_byte_valid) begin
            if (wait_cyc == 2000) give_up("no byte returned for a host request");
            wait_cyc++;
            @(negedge clk);
        end
        for (i = 0; i < nbytes; i++) begin
            check_value("cpu_byte_valid", cpu_byte_valid, 1);
            check_value("cpu_byte", cpu_byte, exp_word[8*i +: 8]);
            @(negedge clk);
        end
        check_value("cpu_ack", cpu_ack, 1);
        check_value("cpu_byte_valid", cpu_byte_valid, 0);
        cpu_req  = 1'b0;
        wait_cyc = 0;
        @(negedge clk);
        while (cpu_ack) begin
            if (wait_cyc == 100) give_up("cpu_ack stayed high after cpu_req dropped");
            wait_cyc++;
            @(negedge clk);
        end
        host_busy = 1'b0;
    endtask

    task automatic mixed_requests(input int count);
        int n;
        int idle;
        int r;
        n    = 0;
        idle = 0;
        while (n < count) begin
            r = $random(host_seed);
            if (can_read_seed() && (r[0] || !can_read_rand())) begin
                host_request(1'b1, ($unsigned(r) >> 4) % 3);
                n++;
                idle = 0;
            end else if (can_read_rand()) begin
                host_request(1'b0, ($unsigned(r) >> 4) % 3);
                n++;
                idle = 0;
            end else begin
                if (idle == 5000) give_up("no RDSEED or RDRAND data became available");
                idle++;
                @(negedge clk);
            end
        end
    endtask

    // Only RDRAND requests until the full seed queue halts the raw input
    task automatic stall_phase();
        int idle;
        int r;
        idle = 0;
        while (ready_low_run < 300) begin
            if (can_read_rand()) begin
                r = $random(host_seed);
                host_request(1'b0, ($unsigned(r) >> 4) % 3);
            end else begin
                if (idle == 20000) give_up("raw input never halted without RDSEED requests");
                idle++;
                @(negedge clk);
            end
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        raw_bit       = 1'b0;
        raw_valid     = 1'b0;
        cpu_req       = 1'b0;
        cpu_type      = RDRAND_16;
        seed          = 32'hd27b_7685;
        host_seed     = $random(seed);
        errors        = 0;
        checks        = 0;
        m_blk         = '0;
        m_cnt         = 0;
        m_run         = 0;
        m_last        = 1'b0;
        exp_health    = 1'b0;
        drbg_st       = '0;
        seed_count    = 0;
        seeds_read    = 0;
        rand_read     = 0;
        raw_on        = 1'b0;
        host_busy     = 1'b0;
        stretch_left  = 0;
        stretch_val   = 1'b0;
        cyc           = 0;
        ready_low_run = 0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("cpu_ack", cpu_ack, 0);
        check_value("cpu_byte_valid", cpu_byte_valid, 0);
        check_value("health_fail", health_fail, 0);
        check_value("raw_ready", raw_ready, 1);
        raw_on <= 1'b1;  // Raw source starts on the next falling edge
        mixed_requests(40);
        stall_phase();
        mixed_requests(40);
        finish_run();
    end

endmodule

`default_nettype wire
